// ==== source/acq_consts.svh ====
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

// Lane FIFO geometry.
`define ACQ_FIFO_DEPTH 64
`define ACQ_FIFO_AW 6

// Burst lengths in bytes, header included.
`define ACQ_LEN_SHORT 32
`define ACQ_LEN_LONG 64

`endif

// ==== source/acq_pkg.sv ====
`default_nettype none

package acq_pkg;

    // Sequencer states, in handshake order.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_CHECK,
        ST_DONE_CHECK,
        ST_WAIT_CONF,
        ST_DONE_CONF,
        ST_WAIT_READ,
        ST_FILL,
        ST_DONE_READ
    } acq_state_t;

    typedef logic [7:0] byte_t;
    typedef logic [11:0] burst_len_t;
    typedef logic [15:0] chip_id_t;
    typedef logic [1:0] dev_kind_t;

endpackage

`default_nettype wire

// ==== source/acq_seq_fsm.sv ====
`default_nettype none

module acq_seq_fsm (
    input  logic clk,
    input  logic rst,
    input  logic fs_check,
    input  logic fs_conf,
    input  logic fs_read,
    input  logic lanes_done,
    output logic fd_check,
    output logic fd_conf,
    output logic fd_read,
    output logic fill
);

    import acq_pkg::*;

    acq_state_t state;
    acq_state_t next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Each stage waits for its start, then holds done until start drops.
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                next_state = ST_WAIT_CHECK;
            end
            ST_WAIT_CHECK: begin
                if (fs_check) begin
                    next_state = ST_DONE_CHECK;
                end
            end
            ST_DONE_CHECK: begin
                if (!fs_check) begin
                    next_state = ST_WAIT_CONF;
                end
            end
            ST_WAIT_CONF: begin
                if (fs_conf) begin
                    next_state = ST_DONE_CONF;
                end
            end
            ST_DONE_CONF: begin
                if (!fs_conf) begin
                    next_state = ST_WAIT_READ;
                end
            end
            ST_WAIT_READ: begin
                if (fs_read) begin
                    next_state = ST_FILL;
                end
            end
            ST_FILL: begin
                // Both lanes must have finished their bursts.
                if (lanes_done) begin
                    next_state = ST_DONE_READ;
                end
            end
            ST_DONE_READ: begin
                // Reads repeat; check and conf are not revisited.
                if (!fs_read) begin
                    next_state = ST_WAIT_READ;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign fd_check = (state == ST_DONE_CHECK);
    assign fd_conf = (state == ST_DONE_CONF);
    assign fd_read = (state == ST_DONE_READ);
    assign fill = (state == ST_FILL);

endmodule

`default_nettype wire

// ==== source/burst_counter.sv ====
`default_nettype none

module burst_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  acq_pkg::burst_len_t len,
    input  logic               step,
    output acq_pkg::burst_len_t count,
    output logic               zero
);

    // Load wins over step; the count saturates at zero.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= len;
        end else if (step && !zero) begin
            count <= count - 1'b1;
        end
    end

    assign zero = (count == '0);

endmodule

`default_nettype wire

// ==== source/lane_writer.sv ====
`default_nettype none

module lane_writer (
    input  logic               clk,
    input  logic               rst,
    input  logic               fill,
    input  acq_pkg::burst_len_t len,
    input  acq_pkg::chip_id_t   chip_id,
    input  logic               fifo_full,
    output acq_pkg::byte_t      wr_data,
    output logic               wr_en,
    output logic               lane_done
);

    import acq_pkg::*;

    logic       busy;
    logic       done;
    logic       start;
    logic       last;
    burst_len_t remaining;
    burst_len_t idx;
    burst_len_t payload;

    assign start = fill && !busy && !done;

    burst_counter u_count (
        .clk   (clk),
        .rst   (rst),
        .load  (start),
        .len   (len),
        .step  (wr_en),
        .count (remaining),
        .zero  (last)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx <= '0;
        end else if (!fill) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            idx <= '0;
        end else if (busy && last) begin
            busy <= 1'b0;
            done <= 1'b1;
        end else if (wr_en) begin
            idx <= idx + 1'b1;
        end
    end

    // Two id bytes, high first, then a count from zero.
    assign payload = idx - burst_len_t'(2);

    always_comb begin
        case (idx)
            burst_len_t'(0): wr_data = chip_id[15:8];
            burst_len_t'(1): wr_data = chip_id[7:0];
            default:         wr_data = payload[7:0];
        endcase
    end

    assign wr_en = busy && !fifo_full && (remaining != '0);
    assign lane_done = done;

endmodule

`default_nettype wire

// ==== source/byte_fifo.sv ====
`default_nettype none

`include "acq_consts.svh"

module byte_fifo #(
    parameter int DEPTH = `ACQ_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           rst,
    input  acq_pkg::byte_t wr_data,
    input  logic           wr_en,
    input  logic           rd_en,
    output acq_pkg::byte_t rd_data,
    output logic           full,
    output logic           empty,
    output logic           underflow
);

    import acq_pkg::*;

    localparam int AW = `ACQ_FIFO_AW;

    byte_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Head byte is visible without a pop.
    assign rd_data = mem[rd_ptr];

    assign full = (level == (AW + 1)'(DEPTH));
    assign empty = (level == '0);
    assign underflow = rd_en && empty;

endmodule

`default_nettype wire

// ==== source/acq_top.sv ====
`default_nettype none

`include "acq_consts.svh"

module acq_top (
    input  logic               clk,
    input  logic               rst,
    output logic               err,
    input  acq_pkg::dev_kind_t dev_kind,
    input  logic [31:0]        intan_id,
    input  logic               fs_check,
    input  logic               fs_conf,
    input  logic               fs_read,
    output logic               fd_check,
    output logic               fd_conf,
    output logic               fd_read,
    input  logic [1:0]         rx_en,
    output logic [15:0]        rx_data,
    output logic [1:0]         fifo_full,
    output logic [1:0]         fifo_empty
);

    import acq_pkg::*;

    logic       fill;
    logic       lanes_done;
    logic [1:0] lane_done;
    logic [1:0] wr_en;
    logic [1:0] underflow;
    byte_t      wr_data [2];
    burst_len_t lane_len [2];

    acq_seq_fsm u_seq (
        .clk        (clk),
        .rst        (rst),
        .fs_check   (fs_check),
        .fs_conf    (fs_conf),
        .fs_read    (fs_read),
        .lanes_done (lanes_done),
        .fd_check   (fd_check),
        .fd_conf    (fd_conf),
        .fd_read    (fd_read),
        .fill       (fill)
    );

    assign lanes_done = &lane_done;

    // Burst length per lane from the device kind.
    always_comb begin
        case (dev_kind)
            2'b01: begin
                lane_len[1] = burst_len_t'(`ACQ_LEN_SHORT);
                lane_len[0] = '0;
            end
            2'b10: begin
                lane_len[1] = burst_len_t'(`ACQ_LEN_LONG);
                lane_len[0] = '0;
            end
            2'b11: begin
                lane_len[1] = burst_len_t'(`ACQ_LEN_LONG);
                lane_len[0] = burst_len_t'(`ACQ_LEN_LONG);
            end
            default: begin
                lane_len[1] = '0;
                lane_len[0] = '0;
            end
        endcase
    end

    for (genvar i = 0; i < 2; i++) begin : g_lane
        lane_writer u_writer (
            .clk       (clk),
            .rst       (rst),
            .fill      (fill),
            .len       (lane_len[i]),
            .chip_id   (intan_id[16*i +: 16]),
            .fifo_full (fifo_full[i]),
            .wr_data   (wr_data[i]),
            .wr_en     (wr_en[i]),
            .lane_done (lane_done[i])
        );

        byte_fifo #(
            .DEPTH (`ACQ_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .wr_data   (wr_data[i]),
            .wr_en     (wr_en[i]),
            .rd_en     (rx_en[i]),
            .rd_data   (rx_data[8*i +: 8]),
            .full      (fifo_full[i]),
            .empty     (fifo_empty[i]),
            .underflow (underflow[i])
        );
    end

    // Any pop of an empty lane latches the error.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err <= 1'b0;
        end else if (|underflow) begin
            err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/acq_checker.sv ====
`default_nettype none

module acq_checker (
    input logic       clk,
    input logic       rst,
    input logic       fs_read,
    input logic       fd_check,
    input logic       fd_conf,
    input logic       fd_read,
    input logic [1:0] wr_en,
    input logic [1:0] fifo_full,
    input logic       err
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // The sequencer answers one stage at a time.
    one_done_at_a_time: assert property (
        @(posedge clk) disable iff (rst) $onehot0({fd_check, fd_conf, fd_read})
    ) else begin
        failures++;
        $error("more than one done output is high");
    end

    // Read done only answers a start that was held at the previous edge.
    read_done_needs_start: assert property (
        @(posedge clk) disable iff (rst) fd_read |-> $past(fs_read)
    ) else begin
        failures++;
        $error("fd_read is high without fs_read");
    end

    // Writers stall on a full FIFO.
    no_write_when_full: assert property (
        @(posedge clk) disable iff (rst) (wr_en & fifo_full) == 2'b00
    ) else begin
        failures++;
        $error("a lane FIFO was written while full");
    end

    // err is sticky until reset.
    err_sticky: assert property (
        @(posedge clk) $fell(err) |-> rst
    ) else begin
        failures++;
        $error("err dropped without reset");
    end

endmodule

bind acq_top acq_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .fs_read   (fs_read),
    .fd_check  (fd_check),
    .fd_conf   (fd_conf),
    .fd_read   (fd_read),
    .wr_en     (wr_en),
    .fifo_full (fifo_full),
    .err       (err)
);

`default_nettype wire

// ==== testbench/acq_tb.sv ====
`default_nettype none

`include "acq_consts.svh"

module acq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 400;
    localparam int NUM_ROWS = 5;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] id;
        logic [11:0] len1;
        logic [11:0] len0;
    } read_row_t;

    logic        clk;
    logic        rst;
    logic        err;
    logic [1:0]  dev_kind;
    logic [31:0] intan_id;
    logic        fs_check;
    logic        fs_conf;
    logic        fs_read;
    logic        fd_check;
    logic        fd_conf;
    logic        fd_read;
    logic [1:0]  rx_en;
    logic [15:0] rx_data;
    logic [1:0]  fifo_full;
    logic [1:0]  fifo_empty;

    int errors;
    int checks;
    int tests;
    int bad_tests;
    int test_mark;

    // Device kind, lane ids (lane 1 high), expected burst length of lane 1 and lane 0.
    read_row_t rows [NUM_ROWS] = '{
        '{2'b00, 32'hA5C3_1E77, 12'd0, 12'd0},
        '{2'b01, 32'h1234_ABCD, 12'(`ACQ_LEN_SHORT), 12'd0},
        '{2'b10, 32'hFE01_0080, 12'(`ACQ_LEN_LONG), 12'd0},
        '{2'b11, 32'h7F3C_C9D2, 12'(`ACQ_LEN_LONG), 12'(`ACQ_LEN_LONG)},
        '{2'b11, 32'h8000_00FF, 12'(`ACQ_LEN_LONG), 12'(`ACQ_LEN_LONG)}
    };

    acq_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .err        (err),
        .dev_kind   (dev_kind),
        .intan_id   (intan_id),
        .fs_check   (fs_check),
        .fs_conf    (fs_conf),
        .fs_read    (fs_read),
        .fd_check   (fd_check),
        .fd_conf    (fd_conf),
        .fd_read    (fd_read),
        .rx_en      (rx_en),
        .rx_data    (rx_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // Header is the lane id, high byte first, then a count from zero.
    function automatic logic [7:0] burst_byte(input logic [15:0] id, input int k);
        if (k == 0) begin
            return id[15:8];
        end else if (k == 1) begin
            return id[7:0];
        end
        return 8'((k - 2) % 256);
    endfunction

    task automatic set_start(input int idx, input logic value);
        case (idx)
            0: fs_check = value;
            1: fs_conf = value;
            default: fs_read = value;
        endcase
    endtask

    // idx 0 is check, 1 is conf, 2 is read.
    task automatic wait_done_level(input int idx, input logic level, input string name,
                                   output int cycles);
        logic [2:0] fd;
        cycles = 0;
        fd = {fd_read, fd_conf, fd_check};
        while (fd[idx] !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            fd = {fd_read, fd_conf, fd_check};
        end
        if (fd[idx] !== level) begin
            report_error($sformatf("%s did not go to %0d in time", name, level));
        end
    endtask

    task automatic run_handshake(input int idx, input string name);
        int cycles;
        @(negedge clk);
        set_start(idx, 1'b1);
        wait_done_level(idx, 1'b1, name, cycles);
        check_value({name, " rise latency"}, cycles, 1);
        check_value("fd_read,fd_conf,fd_check", {fd_read, fd_conf, fd_check}, 3'b001 << idx);
        set_start(idx, 1'b0);
        wait_done_level(idx, 1'b0, name, cycles);
        check_value({name, " fall latency"}, cycles, 1);
    endtask

    // Pops total bytes from one lane; the burst pattern repeats every len bytes.
    task automatic drain_lane(input int lane, input logic [15:0] id, input int len,
                              input int total);
        int n;
        int wait_cycles;
        int gap;
        for (n = 0; n < total; n++) begin
            wait_cycles = 0;
            while (fifo_empty[lane] !== 1'b0 && wait_cycles < TIMEOUT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (fifo_empty[lane] !== 1'b0) begin
                report_error($sformatf("lane %0d stayed empty before byte %0d", lane, n));
                return;
            end
            check_value($sformatf("rx_data lane %0d byte %0d", lane, n),
                        rx_data[8*lane +: 8], burst_byte(id, n % len));
            rx_en[lane] = 1'b1;
            @(negedge clk);
            rx_en[lane] = 1'b0;
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
        end
        check_value($sformatf("fifo_empty[%0d]", lane), fifo_empty[lane], 1'b1);
    endtask

    task automatic run_read(input int row);
        int cycles;
        int bound;
        @(negedge clk);
        dev_kind = rows[row].kind;
        intan_id = rows[row].id;
        fs_read = 1'b1;
        wait_done_level(2, 1'b1, "fd_read", cycles);
        // One cycle into fill, then the burst plus three.
        bound = int'((rows[row].len1 > rows[row].len0) ? rows[row].len1 : rows[row].len0) + 4;
        if (cycles > bound) begin
            report_error($sformatf("fd_read took %0d cycles, limit is %0d", cycles, bound));
        end
        fs_read = 1'b0;
        wait_done_level(2, 1'b0, "fd_read", cycles);
        drain_lane(1, rows[row].id[31:16], rows[row].len1, rows[row].len1);
        drain_lane(0, rows[row].id[15:0], rows[row].len0, rows[row].len0);
        check_value("fifo_empty", fifo_empty, 2'b11);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_idle();
        check_value("fd_read,fd_conf,fd_check", {fd_read, fd_conf, fd_check}, 3'b000);
        check_value("err", err, 1'b0);
        check_value("fifo_empty", fifo_empty, 2'b11);
        check_value("fifo_full", fifo_full, 2'b00);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_mark) begin
            $display("test %s: ok", name);
        end else begin
            bad_tests++;
            $display("test %s: %0d errors", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    initial begin
        int rand_init;
        int cycles;
        rand_init = $urandom(32'h0462_0be7);
        clk = 1'b0;
        rst = 1'b1;
        dev_kind = '0;
        intan_id = '0;
        fs_check = 1'b0;
        fs_conf = 1'b0;
        fs_read = 1'b0;
        rx_en = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        bad_tests = 0;
        test_mark = 0;

        apply_reset();
        check_idle();
        end_test("reset");

        // Starts out of order are ignored while waiting for check.
        @(negedge clk);
        fs_read = 1'b1;
        fs_conf = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_value("fd_read,fd_conf,fd_check", {fd_read, fd_conf, fd_check}, 3'b000);
        end
        fs_read = 1'b0;
        fs_conf = 1'b0;
        run_handshake(0, "fd_check");
        run_handshake(1, "fd_conf");
        end_test("handshakes");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_read(r);
            end_test($sformatf("read row %0d", r));
        end

        // Fill lane 1 to the brim, then ask for another burst.
        @(negedge clk);
        dev_kind = 2'b10;
        intan_id = 32'h3C5A_96E1;
        fs_read = 1'b1;
        wait_done_level(2, 1'b1, "fd_read", cycles);
        fs_read = 1'b0;
        wait_done_level(2, 1'b0, "fd_read", cycles);
        check_value("fifo_full", fifo_full, 2'b10);
        fs_read = 1'b1;
        repeat (2 * `ACQ_LEN_LONG) begin
            @(negedge clk);
            check_value("fd_read", fd_read, 1'b0);
        end
        drain_lane(1, 16'h3C5A, `ACQ_LEN_LONG, 2 * `ACQ_LEN_LONG);
        wait_done_level(2, 1'b1, "fd_read", cycles);
        fs_read = 1'b0;
        wait_done_level(2, 1'b0, "fd_read", cycles);
        check_value("fifo_empty", fifo_empty, 2'b11);
        end_test("back-pressure");

        @(negedge clk);
        check_value("err", err, 1'b0);
        rx_en[0] = 1'b1;
        @(negedge clk);
        rx_en[0] = 1'b0;
        check_value("err", err, 1'b1);
        repeat (5) @(negedge clk);
        check_value("err", err, 1'b1);
        apply_reset();
        check_idle();
        end_test("underflow error");

        if (u_dut.u_checker.failures != 0) begin
            report_error($sformatf("%0d assertion failures in the bound checker",
                                   u_dut.u_checker.failures));
        end

        $display("tests: %0d, with errors: %0d, checks: %0d, errors: %0d",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/acq_pkg.sv
source/acq_seq_fsm.sv
source/burst_counter.sv
source/lane_writer.sv
source/byte_fifo.sv
source/acq_top.sv
testbench/acq_checker.sv
testbench/acq_tb.sv
